/* design/gpu_setup_pkg.sv */
package gpu_setup_pkg;

    // ========================================================================
    // Widths
    // ========================================================================

    typedef logic [6:0]  addr_t;    // Register address
    typedef logic [63:0] data_t;    // Command write or read word
    typedef logic [15:0] coord_t;   // X/Y Q12.4 signed, Z unsigned, Q as Q1.15
    typedef logic [31:0] color_t;   // RGBA8888
    typedef logic [31:0] uv_t;      // Packed UV pair
    typedef logic [1:0]  slot_t;    // Vertex buffer slot index

    // Primitive requested by a vertex write
    typedef enum logic [1:0] {
        KICK_NONE = 2'd0,           // Buffer only
        KICK_012  = 2'd1,           // Triangle in (0,1,2) order
        KICK_021  = 2'd2,           // Triangle in (0,2,1) order
        KICK_RECT = 2'd3            // Two-corner rectangle
    } kick_e;

    // ========================================================================
    // Register map
    // ========================================================================

    localparam addr_t ADDR_COLOR            = 7'h00; // Diffuse hi, specular lo
    localparam addr_t ADDR_UV0_UV1          = 7'h01; // UV1 hi, UV0 lo
    localparam addr_t ADDR_VERTEX_NOKICK    = 7'h06;
    localparam addr_t ADDR_VERTEX_KICK_012  = 7'h07;
    localparam addr_t ADDR_VERTEX_KICK_021  = 7'h08;
    localparam addr_t ADDR_VERTEX_KICK_RECT = 7'h09;
    localparam addr_t ADDR_ID               = 7'h7F; // Read only

    // Vertex write word, low to high
    //   [15:0]  X
    //   [31:16] Y
    //   [47:32] Z
    //   [63:48] Q

    // ========================================================================
    // Identification and sizes
    // ========================================================================

    localparam logic [15:0] GPU_VERSION = 16'h0A00; // Major 10, minor 0

    // Triangle needs three buffered vertices
    localparam int NUM_SLOTS = 3;

    // ========================================================================
    // Reset values
    // ========================================================================

    localparam data_t COLOR_RESET = 64'h0;  // Black, no specular
    localparam data_t UV_RESET    = 64'h0;  // Both UV pairs at origin
    localparam slot_t SLOT_RESET  = 2'd0;   // Strip starts at slot 0

endpackage

/* design/vertex_if.sv */
// One assembled vertex from decode to assembly, no back-pressure
interface vertex_if;

    logic                  valid;   // Single-cycle strobe
    gpu_setup_pkg::kick_e  kick;    // Primitive to emit with this vertex

    // Position
    gpu_setup_pkg::coord_t x;
    gpu_setup_pkg::coord_t y;
    gpu_setup_pkg::coord_t z;
    gpu_setup_pkg::coord_t q;

    // Attributes current at the vertex write
    gpu_setup_pkg::color_t color0;  // Diffuse
    gpu_setup_pkg::color_t color1;  // Specular
    gpu_setup_pkg::uv_t    uv0;
    gpu_setup_pkg::uv_t    uv1;

    modport src (
        output valid, kick, x, y, z, q,
        output color0, color1, uv0, uv1
    );

    modport dst (
        input valid, kick, x, y, z, q,
        input color0, color1, uv0, uv1
    );

endinterface

/* design/cmd_decode.sv */
// Stage 1 of the vertex path
module cmd_decode #(
    parameter logic [15:0] DEVICE_ID = 16'h6702
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // Command port
    input  logic                 cmd_valid,
    input  logic                 cmd_rw,        // 1 read, 0 write
    input  gpu_setup_pkg::addr_t cmd_addr,
    input  gpu_setup_pkg::data_t cmd_wdata,
    output gpu_setup_pkg::data_t cmd_rdata,

    // Toward vertex assembly
    vertex_if.src                vtx
);

    gpu_setup_pkg::data_t cur_color;    // Current COLOR register
    gpu_setup_pkg::data_t cur_uv;       // Current UV0_UV1 register
    gpu_setup_pkg::data_t id_word;
    gpu_setup_pkg::kick_e kick_d;       // Kick decoded from address
    logic                 cmd_wr;
    logic                 vtx_hit;      // Address is one of the vertex registers

    assign cmd_wr  = cmd_valid && !cmd_rw;
    assign id_word = {16'h0, gpu_setup_pkg::GPU_VERSION, 16'h0, DEVICE_ID};

    // ========================================================================
    // Vertex address decode
    // ========================================================================

    always_comb begin
        vtx_hit = 1'b1;
        kick_d  = gpu_setup_pkg::KICK_NONE;
        case (cmd_addr)
            gpu_setup_pkg::ADDR_VERTEX_NOKICK:    kick_d = gpu_setup_pkg::KICK_NONE;
            gpu_setup_pkg::ADDR_VERTEX_KICK_012:  kick_d = gpu_setup_pkg::KICK_012;
            gpu_setup_pkg::ADDR_VERTEX_KICK_021:  kick_d = gpu_setup_pkg::KICK_021;
            gpu_setup_pkg::ADDR_VERTEX_KICK_RECT: kick_d = gpu_setup_pkg::KICK_RECT;
            default: begin
                vtx_hit = 1'b0;                 // Attribute, ID or unused
            end
        endcase
    end

    // ========================================================================
    // Current attributes
    // ========================================================================

    // Visible to the next vertex write and to reads after this edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_color <= gpu_setup_pkg::COLOR_RESET;
            cur_uv    <= gpu_setup_pkg::UV_RESET;
        end else if (cmd_wr) begin
            if (cmd_addr == gpu_setup_pkg::ADDR_COLOR) begin
                cur_color <= cmd_wdata;
            end
            if (cmd_addr == gpu_setup_pkg::ADDR_UV0_UV1) begin
                cur_uv <= cmd_wdata;
            end
        end
    end

    // ========================================================================
    // Vertex strobe and payload
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vtx.valid <= 1'b0;
        end else begin
            vtx.valid <= cmd_wr && vtx_hit;     // One cycle per vertex write
        end
    end

    // Payload only means something while valid is high
    always_ff @(posedge clk) begin
        if (cmd_wr && vtx_hit) begin
            vtx.kick   <= kick_d;
            vtx.x      <= cmd_wdata[15:0];
            vtx.y      <= cmd_wdata[31:16];
            vtx.z      <= cmd_wdata[47:32];
            vtx.q      <= cmd_wdata[63:48];
            vtx.color0 <= cur_color[63:32];     // Diffuse
            vtx.color1 <= cur_color[31:0];      // Specular
            vtx.uv0    <= cur_uv[31:0];
            vtx.uv1    <= cur_uv[63:32];
        end
    end

    // ========================================================================
    // Register read
    // ========================================================================

    // Same-cycle read data, no side effects
    always_comb begin
        case (cmd_addr)
            gpu_setup_pkg::ADDR_COLOR:   cmd_rdata = cur_color;
            gpu_setup_pkg::ADDR_UV0_UV1: cmd_rdata = cur_uv;
            gpu_setup_pkg::ADDR_ID:      cmd_rdata = id_word;
            default: begin
                cmd_rdata = '0;                 // Vertex registers are write only
            end
        endcase
    end

endmodule

/* design/vertex_assembler.sv */
// Stage 2 of the vertex path
module vertex_assembler (
    input  logic                        clk,
    input  logic                        rst_n,

    // From command decode
    vertex_if.dst                       vtx,

    // Primitive output
    output logic                        tri_valid,
    output logic                        rect_valid,
    output gpu_setup_pkg::coord_t [2:0] tri_x,
    output gpu_setup_pkg::coord_t [2:0] tri_y,
    output gpu_setup_pkg::coord_t [2:0] tri_z,
    output gpu_setup_pkg::coord_t [2:0] tri_q,
    output gpu_setup_pkg::color_t [2:0] tri_color0,
    output gpu_setup_pkg::color_t [2:0] tri_color1,
    output gpu_setup_pkg::uv_t    [2:0] tri_uv0,
    output gpu_setup_pkg::uv_t    [2:0] tri_uv1
);

    // Whole vertex as one word, X in the top bits and UV1 in the bottom
    localparam int VTX_W = 4 * $bits(gpu_setup_pkg::coord_t)
                         + 2 * $bits(gpu_setup_pkg::color_t)
                         + 2 * $bits(gpu_setup_pkg::uv_t);
    localparam int NUM_CORNERS = 3;

    localparam gpu_setup_pkg::slot_t LAST_SLOT =
        gpu_setup_pkg::slot_t'(gpu_setup_pkg::NUM_SLOTS - 1);

    typedef logic [VTX_W-1:0] vtx_t;

    vtx_t                 slot_q   [gpu_setup_pkg::NUM_SLOTS];  // Vertex buffer
    vtx_t                 corner_q [NUM_CORNERS];               // Emitted corners
    vtx_t                 vtx_new;
    gpu_setup_pkg::slot_t count_q;      // Slot for the next vertex
    gpu_setup_pkg::slot_t count_inc;
    gpu_setup_pkg::slot_t count_prev;   // Slot written by the last vertex

    assign vtx_new = {vtx.x, vtx.y, vtx.z, vtx.q,
                      vtx.color0, vtx.color1, vtx.uv0, vtx.uv1};

    // Modulo 3 neighbours of the count
    assign count_inc  = (count_q == LAST_SLOT) ? gpu_setup_pkg::SLOT_RESET
                                               : gpu_setup_pkg::slot_t'(count_q + 2'd1);
    assign count_prev = (count_q == gpu_setup_pkg::SLOT_RESET) ? LAST_SLOT
                                               : gpu_setup_pkg::slot_t'(count_q - 2'd1);

    // ========================================================================
    // Vertex buffer and count
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= gpu_setup_pkg::SLOT_RESET;
            for (int i = 0; i < gpu_setup_pkg::NUM_SLOTS; i++) begin
                slot_q[i] <= '0;
            end
        end else if (vtx.valid) begin
            slot_q[count_q] <= vtx_new;         // Every vertex is buffered
            count_q         <= count_inc;
        end
    end

    // ========================================================================
    // Primitive emit
    // ========================================================================

    // Corners come from slot contents before this vertex lands
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tri_valid  <= 1'b0;
            rect_valid <= 1'b0;
            for (int i = 0; i < NUM_CORNERS; i++) begin
                corner_q[i] <= '0;
            end
        end else begin
            tri_valid  <= 1'b0;                 // Strobes last one cycle
            rect_valid <= 1'b0;
            if (vtx.valid) begin
                case (vtx.kick)
                    gpu_setup_pkg::KICK_012: begin
                        tri_valid   <= 1'b1;
                        corner_q[0] <= slot_q[0];
                        corner_q[1] <= slot_q[1];
                        corner_q[2] <= vtx_new;
                    end
                    gpu_setup_pkg::KICK_021: begin
                        tri_valid   <= 1'b1;
                        corner_q[0] <= slot_q[0];
                        corner_q[1] <= vtx_new;     // Swapped winding
                        corner_q[2] <= slot_q[1];
                    end
                    gpu_setup_pkg::KICK_RECT: begin
                        rect_valid  <= 1'b1;
                        corner_q[0] <= slot_q[count_prev]; // Opposite corner
                        corner_q[1] <= vtx_new;     // Entry 2 holds
                    end
                    default: begin
                        // No kick, buffer only
                    end
                endcase
            end
        end
    end

    // Split corner words back into fields
    always_comb begin
        for (int i = 0; i < NUM_CORNERS; i++) begin
            {tri_x[i], tri_y[i], tri_z[i], tri_q[i],
             tri_color0[i], tri_color1[i], tri_uv0[i], tri_uv1[i]} = corner_q[i];
        end
    end

endmodule

/* design/gpu_setup_top.sv */
// Vertex path of the GPU register file
module gpu_setup_top #(
    parameter logic [15:0] DEVICE_ID = 16'h6702     // Low half of the ID word
) (
    input  logic                        clk,
    input  logic                        rst_n,

    // Command port, single-cycle strobe
    input  logic                        cmd_valid,
    input  logic                        cmd_rw,     // 1 read, 0 write
    input  gpu_setup_pkg::addr_t        cmd_addr,
    input  gpu_setup_pkg::data_t        cmd_wdata,
    output gpu_setup_pkg::data_t        cmd_rdata,  // Combinational

    // Primitive output, two cycles after the kick command
    output logic                        tri_valid,
    output logic                        rect_valid,
    output gpu_setup_pkg::coord_t [2:0] tri_x,
    output gpu_setup_pkg::coord_t [2:0] tri_y,
    output gpu_setup_pkg::coord_t [2:0] tri_z,
    output gpu_setup_pkg::coord_t [2:0] tri_q,
    output gpu_setup_pkg::color_t [2:0] tri_color0,
    output gpu_setup_pkg::color_t [2:0] tri_color1,
    output gpu_setup_pkg::uv_t    [2:0] tri_uv0,
    output gpu_setup_pkg::uv_t    [2:0] tri_uv1
);

    // Decode to assembly link
    vertex_if vtx_bus ();

    // Attributes, vertex strobes, reads
    cmd_decode #(
        .DEVICE_ID (DEVICE_ID)
    ) u_cmd_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_rw    (cmd_rw),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_rdata (cmd_rdata),
        .vtx       (vtx_bus.src)
    );

    // Slot buffer and primitive registers
    vertex_assembler u_vertex_assembler (
        .clk        (clk),
        .rst_n      (rst_n),
        .vtx        (vtx_bus.dst),
        .tri_valid  (tri_valid),
        .rect_valid (rect_valid),
        .tri_x      (tri_x),
        .tri_y      (tri_y),
        .tri_z      (tri_z),
        .tri_q      (tri_q),
        .tri_color0 (tri_color0),
        .tri_color1 (tri_color1),
        .tri_uv0    (tri_uv0),
        .tri_uv1    (tri_uv1)
    );

endmodule

/* verif/tb_gpu_setup.sv */
module tb_gpu_setup;

    localparam int          CLK_PERIOD  = 20;
    localparam int          HALF_PERIOD = CLK_PERIOD / 2;
    localparam logic [15:0] DEVICE_ID   = 16'h6702;        // Top level default
    localparam logic [31:0] LFSR_SEED   = 32'h3d7dca70;

    // Commands issued by the six tests in order
    localparam int NUM_CMDS    = 4 + 34 + 7 + 6 + 3 + 30;
    localparam int CYCLE_LIMIT = 4 * NUM_CMDS + 100;

    localparam int DRAIN_CYCLES = 4;        // Kick latency plus margin

    // ID word built from its fields
    localparam gpu_setup_pkg::data_t ID_EXP =
        (gpu_setup_pkg::data_t'(gpu_setup_pkg::GPU_VERSION) << 32)
        | gpu_setup_pkg::data_t'(DEVICE_ID);

    typedef struct packed {
        gpu_setup_pkg::coord_t x, y, z, q;
        gpu_setup_pkg::color_t color0, color1;
        gpu_setup_pkg::uv_t    uv0, uv1;
    } vertex_t;

    typedef struct packed {
        gpu_setup_pkg::kick_e kind;
        vertex_t [2:0]        corner;
        logic [63:0]          due;          // Drive edge plus two cycles
    } prim_t;

    logic                        clk;
    logic                        rst_n;
    logic                        cmd_valid;
    logic                        cmd_rw;
    gpu_setup_pkg::addr_t        cmd_addr;
    gpu_setup_pkg::data_t        cmd_wdata;
    gpu_setup_pkg::data_t        cmd_rdata;
    logic                        tri_valid;
    logic                        rect_valid;
    gpu_setup_pkg::coord_t [2:0] tri_x, tri_y, tri_z, tri_q;
    gpu_setup_pkg::color_t [2:0] tri_color0, tri_color1;
    gpu_setup_pkg::uv_t    [2:0] tri_uv0, tri_uv1;

    // Model state
    gpu_setup_pkg::data_t m_color;
    gpu_setup_pkg::data_t m_uv;
    vertex_t              m_slot [gpu_setup_pkg::NUM_SLOTS];
    int                   m_count;          // Next slot to fill
    vertex_t [2:0]        m_corner;         // Last emitted corners
    prim_t                exp_q [$];
    prim_t                cur_prim;
    logic [31:0]          lfsr;
    int                   err_count;
    int                   check_count;
    int                   test_err_base;

    gpu_setup_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_rw     (cmd_rw),
        .cmd_addr   (cmd_addr),
        .cmd_wdata  (cmd_wdata),
        .cmd_rdata  (cmd_rdata),
        .tri_valid  (tri_valid),
        .rect_valid (rect_valid),
        .tri_x      (tri_x),
        .tri_y      (tri_y),
        .tri_z      (tri_z),
        .tri_q      (tri_q),
        .tri_color0 (tri_color0),
        .tri_color1 (tri_color1),
        .tri_uv0    (tri_uv0),
        .tri_uv1    (tri_uv1)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // ========================================================================
    // Stimulus helpers
    // ========================================================================

    // Taps 32, 22, 2, 1
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic gpu_setup_pkg::addr_t kick_addr(input gpu_setup_pkg::kick_e kind);
        case (kind)
            gpu_setup_pkg::KICK_012:  return gpu_setup_pkg::ADDR_VERTEX_KICK_012;
            gpu_setup_pkg::KICK_021:  return gpu_setup_pkg::ADDR_VERTEX_KICK_021;
            gpu_setup_pkg::KICK_RECT: return gpu_setup_pkg::ADDR_VERTEX_KICK_RECT;
            default:                  return gpu_setup_pkg::ADDR_VERTEX_NOKICK;
        endcase
    endfunction

    // Expected corners from the slots before the new vertex lands
    function automatic prim_t ref_prim(input gpu_setup_pkg::kick_e kind, input vertex_t v);
        prim_t p;
        int    prev;
        p.kind   = kind;
        p.corner = m_corner;                // Untouched entries hold
        p.due    = '0;
        prev     = (m_count + gpu_setup_pkg::NUM_SLOTS - 1) % gpu_setup_pkg::NUM_SLOTS;
        case (kind)
            gpu_setup_pkg::KICK_012: begin
                p.corner[0] = m_slot[0];
                p.corner[1] = m_slot[1];
                p.corner[2] = v;
            end
            gpu_setup_pkg::KICK_021: begin
                p.corner[0] = m_slot[0];
                p.corner[1] = v;
                p.corner[2] = m_slot[1];
            end
            gpu_setup_pkg::KICK_RECT: begin
                p.corner[0] = m_slot[prev]; // Slot 0 wraps back to slot 2
                p.corner[1] = v;
            end
            default: begin
            end
        endcase
        return p;
    endfunction

    task automatic drive_cmd(input logic rw, input gpu_setup_pkg::addr_t a,
                             input gpu_setup_pkg::data_t d);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_rw    <= rw;
        cmd_addr  <= a;
        cmd_wdata <= d;
    endtask

    task automatic idle();
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd_rw    <= 1'b0;
    endtask

    task automatic reg_write(input gpu_setup_pkg::addr_t a, input gpu_setup_pkg::data_t d);
        drive_cmd(1'b0, a, d);
        if (a == gpu_setup_pkg::ADDR_COLOR) m_color = d;
        if (a == gpu_setup_pkg::ADDR_UV0_UV1) m_uv = d;
    endtask

    task automatic vertex_write(input gpu_setup_pkg::kick_e kind);
        gpu_setup_pkg::data_t pos;
        vertex_t              v;
        prim_t                p;
        pos      = rand_bits(64);
        v.x      = pos[15:0];
        v.y      = pos[31:16];
        v.z      = pos[47:32];
        v.q      = pos[63:48];
        v.color0 = m_color[63:32];          // Diffuse
        v.color1 = m_color[31:0];           // Specular
        v.uv0    = m_uv[31:0];
        v.uv1    = m_uv[63:32];
        drive_cmd(1'b0, kick_addr(kind), pos);
        if (kind != gpu_setup_pkg::KICK_NONE) begin
            p        = ref_prim(kind, v);
            p.due    = $time + 2 * CLK_PERIOD;
            m_corner = p.corner;
            exp_q.push_back(p);
        end
        m_slot[m_count] = v;
        m_count = (m_count + 1) % gpu_setup_pkg::NUM_SLOTS;
    endtask

    // Wait a bounded time for outstanding primitives and then a few quiet cycles
    task automatic drain();
        int waited;
        idle();
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        repeat (3) idle();
    endtask

    // ========================================================================
    // Compare tasks
    // ========================================================================

    task automatic check_data(input string what, input gpu_setup_pkg::data_t exp,
                              input gpu_setup_pkg::data_t got);
        check_count++;
        if (got !== exp) begin
            $display("ERR %0t: %s read %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_coord(input string what, input gpu_setup_pkg::coord_t exp,
                               input gpu_setup_pkg::coord_t got);
        check_count++;
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_color(input string what, input gpu_setup_pkg::color_t exp,
                               input gpu_setup_pkg::color_t got);
        check_count++;
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_uv(input string what, input gpu_setup_pkg::uv_t exp,
                            input gpu_setup_pkg::uv_t got);
        check_count++;
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic check_kind(input gpu_setup_pkg::kick_e exp, input logic tv, input logic rv);
        logic exp_tri;
        exp_tri = (exp != gpu_setup_pkg::KICK_RECT);
        check_count++;
        if (tv !== exp_tri || rv !== !exp_tri) begin
            $display("ERR %0t: %s strobe, tri_valid %b rect_valid %b",
                     $time, exp.name(), tv, rv);
            err_count++;
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && (tri_valid || rect_valid)) begin
            if (exp_q.size() == 0) begin
                $display("Primitive strobe at time %0t when none was expected", $time);
                err_count++;
            end else begin
                cur_prim = exp_q.pop_front();
                check_count++;
                if ($time != cur_prim.due + HALF_PERIOD) begin
                    $display("ERR %0t: strobe early or late, due at %0t",
                             $time, cur_prim.due);
                    err_count++;
                end
                check_kind(cur_prim.kind, tri_valid, rect_valid);
                for (int i = 0; i < 3; i++) begin
                    check_coord($sformatf("x[%0d]", i), cur_prim.corner[i].x, tri_x[i]);
                    check_coord($sformatf("y[%0d]", i), cur_prim.corner[i].y, tri_y[i]);
                    check_coord($sformatf("z[%0d]", i), cur_prim.corner[i].z, tri_z[i]);
                    check_coord($sformatf("q[%0d]", i), cur_prim.corner[i].q, tri_q[i]);
                    check_color($sformatf("color0[%0d]", i), cur_prim.corner[i].color0,
                                tri_color0[i]);
                    check_color($sformatf("color1[%0d]", i), cur_prim.corner[i].color1,
                                tri_color1[i]);
                    check_uv($sformatf("uv0[%0d]", i), cur_prim.corner[i].uv0, tri_uv0[i]);
                    check_uv($sformatf("uv1[%0d]", i), cur_prim.corner[i].uv1, tri_uv1[i]);
                end
            end
        end
    end

    task automatic report_test(input int n, input string name);
        $display("test %0d %s: done, %0d errors", n, name, err_count - test_err_base);
        test_err_base = err_count;
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        logic [1:0] k;
        rst_n         = 1'b0;
        cmd_valid     = 1'b0;
        cmd_rw        = 1'b0;
        cmd_addr      = '0;
        cmd_wdata     = '0;
        lfsr          = LFSR_SEED;
        m_color       = '0;
        m_uv          = '0;
        m_count       = 0;
        m_corner      = '0;
        err_count     = 0;
        check_count   = 0;
        test_err_base = 0;
        for (int i = 0; i < gpu_setup_pkg::NUM_SLOTS; i++) m_slot[i] = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        repeat (3) idle();                  // Any strobe here is flagged
        reg_read(gpu_setup_pkg::ADDR_ID, ID_EXP, "ID");
        reg_read(gpu_setup_pkg::ADDR_COLOR, '0, "COLOR");
        reg_read(gpu_setup_pkg::ADDR_UV0_UV1, '0, "UV0_UV1");
        reg_read(7'h20, '0, "unused 0x20");
        drain();
        report_test(1, "reset values");

        for (int i = 0; i < 8; i++) begin
            reg_write(gpu_setup_pkg::ADDR_COLOR, rand_bits(64));
            reg_write(gpu_setup_pkg::ADDR_UV0_UV1, rand_bits(64));
            reg_read(gpu_setup_pkg::ADDR_COLOR, m_color, "COLOR");
            reg_read(gpu_setup_pkg::ADDR_UV0_UV1, m_uv, "UV0_UV1");
        end
        reg_write(gpu_setup_pkg::ADDR_ID, rand_bits(64));
        reg_read(gpu_setup_pkg::ADDR_ID, ID_EXP, "ID after write");
        drain();
        report_test(2, "attribute readback");

        // Attributes change between vertices of one strip
        reg_write(gpu_setup_pkg::ADDR_COLOR, rand_bits(64));
        reg_write(gpu_setup_pkg::ADDR_UV0_UV1, rand_bits(64));
        vertex_write(gpu_setup_pkg::KICK_NONE);
        reg_write(gpu_setup_pkg::ADDR_COLOR, rand_bits(64));
        vertex_write(gpu_setup_pkg::KICK_NONE);
        reg_write(gpu_setup_pkg::ADDR_UV0_UV1, rand_bits(64));
        vertex_write(gpu_setup_pkg::KICK_012);
        drain();
        report_test(3, "strip 012");

        reg_write(gpu_setup_pkg::ADDR_COLOR, rand_bits(64));
        vertex_write(gpu_setup_pkg::KICK_NONE);
        vertex_write(gpu_setup_pkg::KICK_NONE);
        vertex_write(gpu_setup_pkg::KICK_021);
        vertex_write(gpu_setup_pkg::KICK_021); // Count wrapped to slot 0
        vertex_write(gpu_setup_pkg::KICK_012);
        drain();
        report_test(4, "kick 021 and wrap");

        for (int i = 0; i < 3; i++) vertex_write(gpu_setup_pkg::KICK_RECT); // Counts 2, 0, 1
        drain();
        report_test(5, "rect at each count");

        for (int i = 0; i < 24; i++) begin
            if (i % 4 == 0) reg_write(gpu_setup_pkg::ADDR_UV0_UV1, rand_bits(64));
            k = 2'(rand_bits(2));
            vertex_write(gpu_setup_pkg::kick_e'(k));
        end
        drain();
        report_test(6, "random back-to-back");

        if (exp_q.size() != 0) begin
            $display("%0d expected primitives never appeared", exp_q.size());
            err_count++;
        end
        $display("6 tests, %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Read data is combinational and checked mid-cycle
    task automatic reg_read(input gpu_setup_pkg::addr_t a, input gpu_setup_pkg::data_t exp,
                            input string what);
        drive_cmd(1'b1, a, '0);
        @(negedge clk);
        check_data(what, exp, cmd_rdata);
    endtask

endmodule

/* vlog.f */
design/gpu_setup_pkg.sv
design/vertex_if.sv
design/cmd_decode.sv
design/vertex_assembler.sv
design/gpu_setup_top.sv
verif/tb_gpu_setup.sv

/* run_verilator.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing -f vlog.f --top-module tb_gpu_setup -o sim_gpu_setup \
    && ./obj_dir/sim_gpu_setup > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log && echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }
